//--- design/mips_alu.sv
`timescale 1ns/100ps
`include "mips_settings.svh"

module mips_alu (
    input  mips_ctrl_pkg::alu_op_t alu_op,
    input  logic [`MIPS_XLEN-1:0]  op_a,
    input  logic [`MIPS_XLEN-1:0]  op_b,
    output logic [`MIPS_XLEN-1:0]  result,
    output logic                   zero
);
    import mips_ctrl_pkg::*;

    localparam int HALF = `MIPS_XLEN / 2;

    always_comb begin
        result = '0;
        case (alu_op)
            ALU_ADD: begin
                result = op_a + op_b;
            end
            ALU_SUB: begin
                result = op_a - op_b;
            end
            ALU_AND: begin
                result = op_a & op_b;
            end
            ALU_OR: begin
                result = op_a | op_b;
            end
            ALU_XOR: begin
                result = op_a ^ op_b;
            end
            ALU_SLTU: begin
                result[0] = (op_a < op_b);
            end
            ALU_LUI: begin
                // Immediate moves to the upper half, low half cleared
                result = {op_b[HALF-1:0], {HALF{1'b0}}};
            end
            default: begin
                result = op_a + op_b;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- design/mips_alu_control.sv
`timescale 1ns/100ps

module mips_alu_control (
    input  mips_ctrl_pkg::alu_class_t alu_class,
    input  mips_isa_pkg::funct_t      funct,
    input  mips_isa_pkg::opcode_t     opcode,
    output mips_ctrl_pkg::alu_op_t    alu_op
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    always_comb begin
        alu_op = ALU_ADD;
        case (alu_class)
            ALU_CLASS_ADD: begin
                alu_op = ALU_ADD;
            end
            ALU_CLASS_SUB: begin
                alu_op = ALU_SUB;
            end
            ALU_CLASS_FUNCT: begin
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLTU: alu_op = ALU_SLTU;
                    default: alu_op = ALU_ADD;
                endcase
            end
            ALU_CLASS_IMM: begin
                // Logic immediates pick the operation from the opcode
                case (opcode)
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    OP_LUI:  alu_op = ALU_LUI;
                    default: alu_op = ALU_ADD;
                endcase
            end
            default: begin
                alu_op = ALU_ADD;
            end
        endcase
    end

endmodule

//--- design/mips_control.sv
`timescale 1ns/100ps

module mips_control (
    input  mips_isa_pkg::opcode_t     opcode,
    output logic                      reg_dst,
    output logic                      branch,
    output logic                      branch_ne,
    output logic                      mem_read,
    output logic                      mem_to_reg,
    output mips_ctrl_pkg::alu_class_t alu_class,
    output logic                      mem_write,
    output logic                      alu_src,
    output logic                      reg_write,
    output logic                      zero_extend,
    output logic                      link
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    always_comb begin
        // Unknown opcodes fall through as a no-op
        reg_dst     = 1'b0;
        branch      = 1'b0;
        branch_ne   = 1'b0;
        mem_read    = 1'b0;
        mem_to_reg  = 1'b0;
        alu_class   = ALU_CLASS_ADD;
        mem_write   = 1'b0;
        alu_src     = 1'b0;
        reg_write   = 1'b0;
        zero_extend = 1'b0;
        link        = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                reg_dst   = 1'b1;
                reg_write = 1'b1;
                alu_class = ALU_CLASS_FUNCT;
            end
            OP_ADDIU: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_LUI: begin
                alu_src     = 1'b1;
                reg_write   = 1'b1;
                zero_extend = 1'b1;
                alu_class   = ALU_CLASS_IMM;
            end
            OP_LW: begin
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ: begin
                branch    = 1'b1;
                alu_class = ALU_CLASS_SUB;
            end
            OP_BNE: begin
                branch_ne = 1'b1;
                alu_class = ALU_CLASS_SUB;
            end
            OP_JAL: begin
                link      = 1'b1;
                reg_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- design/mips_cpu_harvard.sv
`timescale 1ns/100ps
`include "mips_settings.svh"

module mips_cpu_harvard (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  active,
    output logic [`MIPS_XLEN-1:0] register_v0,

    input  logic                  clk_enable,

    output logic [`MIPS_XLEN-1:0] instr_address,
    input  logic [`MIPS_XLEN-1:0] instr_readdata,

    output logic [`MIPS_XLEN-1:0] data_address,
    output logic                  data_write,
    output logic                  data_read,
    output logic [`MIPS_XLEN-1:0] data_writedata,
    input  logic [`MIPS_XLEN-1:0] data_readdata
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    localparam logic [4:0] LINK_REG = 5'd31;

    opcode_t               opcode;
    funct_t                funct;
    logic [4:0]            rs;
    logic [4:0]            rt;
    logic [4:0]            rd;
    logic [15:0]           imm16;

    logic                  reg_dst;
    logic                  branch;
    logic                  branch_ne;
    logic                  mem_read;
    logic                  mem_to_reg;
    alu_class_t            alu_class;
    logic                  mem_write;
    logic                  alu_src;
    logic                  reg_write;
    logic                  zero_extend;
    logic                  link;

    alu_op_t               alu_op;
    logic [`MIPS_XLEN-1:0] imm_sext;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [`MIPS_XLEN-1:0] rs_data;
    logic [`MIPS_XLEN-1:0] rt_data;
    logic [`MIPS_XLEN-1:0] alu_op_b;
    logic [`MIPS_XLEN-1:0] alu_result;
    logic                  alu_zero;
    logic [4:0]            write_index;
    logic [`MIPS_XLEN-1:0] write_data;
    logic [`MIPS_XLEN-1:0] link_address;

    // Instruction fields
    assign opcode = opcode_t'(instr_readdata[31:26]);
    assign rs     = instr_readdata[25:21];
    assign rt     = instr_readdata[20:16];
    assign rd     = instr_readdata[15:11];
    assign imm16  = instr_readdata[15:0];
    assign funct  = funct_t'(instr_readdata[5:0]);

    mips_control i_control (
        .opcode      (opcode),
        .reg_dst     (reg_dst),
        .branch      (branch),
        .branch_ne   (branch_ne),
        .mem_read    (mem_read),
        .mem_to_reg  (mem_to_reg),
        .alu_class   (alu_class),
        .mem_write   (mem_write),
        .alu_src     (alu_src),
        .reg_write   (reg_write),
        .zero_extend (zero_extend),
        .link        (link)
    );

    mips_alu_control i_alu_control (
        .alu_class (alu_class),
        .funct     (funct),
        .opcode    (opcode),
        .alu_op    (alu_op)
    );

    assign imm_sext = {{(`MIPS_XLEN-16){imm16[15]}}, imm16};
    assign imm_ext  = zero_extend ? {{(`MIPS_XLEN-16){1'b0}}, imm16} : imm_sext;
    assign alu_op_b = alu_src ? imm_ext : rt_data;

    // Write-back target and source
    assign write_index = link ? LINK_REG : (reg_dst ? rd : rt);
    assign write_data  = link ? link_address : (mem_to_reg ? data_readdata : alu_result);

    mips_regfile i_regfile (
        .clk          (clk),
        .reset        (reset),
        .clk_enable   (clk_enable),
        .read_index_a (rs),
        .read_index_b (rt),
        .write_index  (write_index),
        .write_enable (reg_write && active),
        .write_data   (write_data),
        .read_data_a  (rs_data),
        .read_data_b  (rt_data),
        .register_v0  (register_v0)
    );

    mips_alu i_alu (
        .alu_op (alu_op),
        .op_a   (rs_data),
        .op_b   (alu_op_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    mips_pc i_pc (
        .clk          (clk),
        .reset        (reset),
        .clk_enable   (clk_enable),
        .instr        (instr_readdata),
        .imm_sext     (imm_sext),
        .zero         (alu_zero),
        .branch       (branch),
        .branch_ne    (branch_ne),
        .rs_data      (rs_data),
        .curr_address (instr_address),
        .link_address (link_address),
        .active       (active)
    );

    // Memory strobes are quiet once halted
    assign data_address   = alu_result;
    assign data_writedata = rt_data;
    assign data_write     = mem_write && active;
    assign data_read      = mem_read && active;

endmodule

//--- design/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

    // Coarse ALU class from the main decoder
    typedef enum logic [1:0] {
        ALU_CLASS_ADD   = 2'd0,
        ALU_CLASS_SUB   = 2'd1,
        ALU_CLASS_FUNCT = 2'd2,
        ALU_CLASS_IMM   = 2'd3
    } alu_class_t;

    // Operation carried out by the ALU
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLTU = 4'd5,
        ALU_LUI  = 4'd6
    } alu_op_t;

endpackage

//--- design/mips_isa_pkg.sv
package mips_isa_pkg;

    // Primary opcode, instruction bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    // R-type function code, instruction bits 5:0
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLTU = 6'h2B
    } funct_t;

endpackage

//--- design/mips_pc.sv
`timescale 1ns/100ps
`include "mips_settings.svh"

module mips_pc (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_enable,
    input  logic [`MIPS_XLEN-1:0] instr,
    input  logic [`MIPS_XLEN-1:0] imm_sext,
    input  logic                  zero,
    input  logic                  branch,
    input  logic                  branch_ne,
    input  logic [`MIPS_XLEN-1:0] rs_data,
    output logic [`MIPS_XLEN-1:0] curr_address,
    output logic [`MIPS_XLEN-1:0] link_address,
    output logic                  active
);
    import mips_isa_pkg::*;

    opcode_t               opcode;
    funct_t                funct;
    logic                  is_jump;
    logic                  is_jr;
    logic                  take_branch;
    logic                  halt;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] branch_target;
    logic [`MIPS_XLEN-1:0] jump_target;
    logic [`MIPS_XLEN-1:0] next_address;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);

    assign is_jump     = (opcode == OP_J) || (opcode == OP_JAL);
    assign is_jr       = (opcode == OP_RTYPE) && (funct == FN_JR);
    assign take_branch = (branch && zero) || (branch_ne && !zero);

    assign pc_plus4      = curr_address + `MIPS_XLEN'd4;
    assign branch_target = pc_plus4 + {imm_sext[`MIPS_XLEN-3:0], 2'b00};
    // Jump stays inside the current 256 MB region
    assign jump_target   = {pc_plus4[`MIPS_XLEN-1:28], instr[25:0], 2'b00};

    // No delay slot, so the return address is the next instruction
    assign link_address = pc_plus4;

    always_comb begin
        if (is_jr) begin
            next_address = rs_data;
        end else if (is_jump) begin
            next_address = jump_target;
        end else if (take_branch) begin
            next_address = branch_target;
        end else begin
            next_address = pc_plus4;
        end
    end

    assign halt = (next_address == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            curr_address <= `MIPS_RESET_VECTOR;
            active       <= 1'b1;
        end else if (clk_enable && active) begin
            active <= !halt;
            // Halted core keeps its last fetch address
            if (!halt) begin
                curr_address <= next_address;
            end
        end
    end

endmodule

//--- design/mips_regfile.sv
`timescale 1ns/100ps
`include "mips_settings.svh"

module mips_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_enable,
    input  logic [4:0]            read_index_a,
    input  logic [4:0]            read_index_b,
    input  logic [4:0]            write_index,
    input  logic                  write_enable,
    input  logic [`MIPS_XLEN-1:0] write_data,
    output logic [`MIPS_XLEN-1:0] read_data_a,
    output logic [`MIPS_XLEN-1:0] read_data_b,
    output logic [`MIPS_XLEN-1:0] register_v0
);
    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (clk_enable && write_enable && (write_index != 5'd0)) begin
            regs[write_index] <= write_data;
        end
    end

    // Register zero is hardwired
    always_comb begin
        if (read_index_a == 5'd0) begin
            read_data_a = '0;
        end else begin
            read_data_a = regs[read_index_a];
        end
    end

    always_comb begin
        if (read_index_b == 5'd0) begin
            read_data_b = '0;
        end else begin
            read_data_b = regs[read_index_b];
        end
    end

    assign register_v0 = regs[`MIPS_V0_INDEX];

endmodule

//--- design/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data and address width
`define MIPS_XLEN 32

// Architectural register count
`define MIPS_NUM_REGS 32

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Index of result register v0
`define MIPS_V0_INDEX 2

`endif

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f verilog.f --top-module mips_cpu_tb -o mips_cpu_sim \
    && ./obj_dir/mips_cpu_sim | tee /dev/stderr | grep -q "Everything OK" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- test/mips_cpu_properties.sv
`timescale 1ns/100ps
`include "mips_settings.svh"

module mips_cpu_properties (
    input logic                  clk,
    input logic                  reset,
    input logic                  clk_enable,
    input logic                  active,
    input logic                  data_read,
    input logic                  data_write,
    input logic [`MIPS_XLEN-1:0] instr_address
);

    // Memory strobes are exclusive
    assert property (@(posedge clk) !(data_read && data_write))
        else $error("data_read and data_write high together");

    assert property (@(posedge clk) reset |=> (instr_address == `MIPS_RESET_VECTOR))
        else $error("instr_address not at reset vector after reset");

    // Stalled edge leaves the fetch address alone
    assert property (@(posedge clk) (!clk_enable && !reset) |=> $stable(instr_address))
        else $error("instr_address moved with clk_enable low");

    assert property (@(posedge clk) (!active && !reset) |=> !active)
        else $error("active rose again without reset");

endmodule

bind mips_cpu_harvard mips_cpu_properties i_properties (
    .clk           (clk),
    .reset         (reset),
    .clk_enable    (clk_enable),
    .active        (active),
    .data_read     (data_read),
    .data_write    (data_write),
    .instr_address (instr_address)
);

//--- test/mips_cpu_tb.sv
`timescale 1ns/100ps
`include "mips_settings.svh"

module mips_cpu_tb;
    import mips_isa_pkg::*;

    localparam int PERIOD = 40;
    localparam int SUB_INDEX = 12;
    localparam logic [4:0] ZERO = 5'd0;
    localparam logic [4:0] V0 = 5'd2;
    localparam logic [4:0] RA = 5'd31;

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] ref_dmem [256];
    logic [31:0] instr_offset;
    logic [31:0] arith_ops [4];
    logic [31:0] expected_v0;
    int          check_addrs [$];
    int          prog_len;
    int          ref_steps;
    string       test_name;
    int          tests_run;
    int          check_count;
    int          error_count;
    int          cycle_count;
    int          deadline_cycle;
    event        run_started;

    mips_cpu_harvard i_dut (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    // Instruction memory starts at the reset vector
    assign instr_offset   = instr_address - `MIPS_RESET_VECTOR;
    assign instr_readdata = imem[instr_offset[9:2]];
    assign data_readdata  = data_read ? dmem[data_address[9:2]] : 32'h0;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h0001_0003) ^ 32'h5a5a_c3c3;
    endfunction

    // Data memory reloads its fill pattern on every reset edge
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fill_word(i * 4);
            end
        end else if (clk_enable && data_write) begin
            dmem[data_address[9:2]] <= data_writedata;
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] enc_r(input funct_t fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_t op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input opcode_t op, input logic [31:0] index);
        logic [31:0] addr;
        addr = `MIPS_RESET_VECTOR + (index << 2);
        return {op, addr[27:2]};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // Offset counts words from the instruction after the branch
    task automatic emit_branch(input opcode_t op, input logic [4:0] rs,
                               input logic [4:0] rt, input int target);
        int offset;
        offset = target - (prog_len + 1);
        emit(enc_i(op, rs, rt, offset[15:0]));
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        emit(enc_i(OP_LUI, ZERO, rd, value[31:16]));
        emit(enc_i(OP_ORI, rd, rd, value[15:0]));
    endtask

    task automatic emit_halt();
        emit(enc_r(FN_JR, ZERO, ZERO, ZERO));
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0;
        end
        prog_len = 0;
        check_addrs.delete();
    endtask

    // Instruction-set model that halts on a jump to zero and has no delay slot
    function automatic logic [31:0] ref_run();
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] offset;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_s;
        logic [31:0] ea;
        logic [31:0] next;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            r[i] = 32'h0;
        end
        for (int i = 0; i < 256; i++) begin
            ref_dmem[i] = fill_word(i * 4);
        end
        pc = `MIPS_RESET_VECTOR;
        next = 32'h1;
        steps = 0;
        while (next != 32'h0 && steps < 4096) begin
            offset = pc - `MIPS_RESET_VECTOR;
            ins = imem[offset[9:2]];
            a = r[ins[25:21]];
            b = r[ins[20:16]];
            imm_s = {{16{ins[15]}}, ins[15:0]};
            ea = a + imm_s;
            next = pc + 32'd4;
            case (opcode_t'(ins[31:26]))
                OP_RTYPE: begin
                    case (funct_t'(ins[5:0]))
                        FN_ADDU: r[ins[15:11]] = a + b;
                        FN_SUBU: r[ins[15:11]] = a - b;
                        FN_AND:  r[ins[15:11]] = a & b;
                        FN_OR:   r[ins[15:11]] = a | b;
                        FN_XOR:  r[ins[15:11]] = a ^ b;
                        FN_SLTU: r[ins[15:11]] = {31'h0, a < b};
                        FN_JR:   next = a;
                        default: ;
                    endcase
                end
                OP_J:     next = {next[31:28], ins[25:0], 2'b00};
                OP_JAL: begin
                    r[31] = next;
                    next = {next[31:28], ins[25:0], 2'b00};
                end
                OP_BEQ:   if (a == b) next = next + {imm_s[29:0], 2'b00};
                OP_BNE:   if (a != b) next = next + {imm_s[29:0], 2'b00};
                OP_ADDIU: r[ins[20:16]] = a + imm_s;
                OP_ANDI:  r[ins[20:16]] = a & {16'h0, ins[15:0]};
                OP_ORI:   r[ins[20:16]] = a | {16'h0, ins[15:0]};
                OP_LUI:   r[ins[20:16]] = {ins[15:0], 16'h0};
                OP_LW:    r[ins[20:16]] = ref_dmem[ea[9:2]];
                OP_SW:    ref_dmem[ea[9:2]] = b;
                default: ;
            endcase
            r[0] = 32'h0;
            steps++;
            pc = next;
        end
        ref_steps = steps;
        return r[V0];
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic build_arith();
        clear_program();
        for (int i = 0; i < 4; i++) begin
            load_const(5'(8 + i), arith_ops[i]);
        end
        emit(enc_r(FN_ADDU, 5'd8, 5'd9, V0));
        emit(enc_r(FN_SUBU, V0, 5'd10, V0));
        emit(enc_r(FN_XOR, V0, 5'd11, V0));
        emit(enc_r(FN_AND, V0, 5'd8, 5'd12));
        emit(enc_r(FN_OR, 5'd12, 5'd9, 5'd13));
        emit(enc_r(FN_XOR, V0, 5'd13, V0));
        emit(enc_r(FN_SLTU, 5'd8, 5'd9, 5'd14));
        emit(enc_r(FN_SLTU, 5'd9, 5'd8, 5'd15));
        emit(enc_r(FN_ADDU, V0, 5'd14, V0));
        emit(enc_r(FN_SUBU, V0, 5'd15, V0));
        // Write to register zero is dropped
        emit(enc_r(FN_ADDU, 5'd8, 5'd9, ZERO));
        emit(enc_r(FN_OR, V0, ZERO, V0));
        emit_halt();
    endtask

    task automatic build_imm();
        clear_program();
        emit(enc_i(OP_ADDIU, ZERO, V0, 16'hFFFB));
        emit(enc_i(OP_ADDIU, V0, 5'd8, 16'h8000));
        emit(enc_i(OP_ANDI, 5'd8, 5'd9, 16'hF0F0));
        emit(enc_i(OP_ORI, 5'd9, 5'd10, 16'h8001));
        emit(enc_i(OP_LUI, ZERO, 5'd11, 16'h8765));
        emit(enc_r(FN_ADDU, 5'd10, 5'd11, V0));
        emit(enc_i(OP_ADDIU, V0, V0, 16'hFFFF));
        emit(enc_r(FN_XOR, V0, 5'd8, V0));
        emit_halt();
    endtask

    task automatic build_mem();
        int          idx;
        logic [31:0] base;
        clear_program();
        for (int k = 0; k < 4; k++) begin
            idx = $urandom % 255;
            base = 32'(idx * 4 + 4);
            load_const(5'(16 + k), base);
            load_const(5'd9, $urandom);
            emit(enc_i(OP_SW, 5'(16 + k), 5'd9, 16'hFFFC));
            check_addrs.push_back(idx);
        end
        for (int k = 3; k >= 0; k--) begin
            emit(enc_i(OP_LW, 5'(16 + k), 5'd10, 16'hFFFC));
            emit(enc_r(FN_XOR, V0, 5'd10, V0));
        end
        // Untouched word still holds the fill pattern
        emit(enc_i(OP_LW, ZERO, 5'd11, 16'h03FC));
        emit(enc_r(FN_ADDU, V0, 5'd11, V0));
        emit_halt();
    endtask

    task automatic build_branch();
        int loop_top;
        clear_program();
        emit(enc_i(OP_ADDIU, ZERO, 5'd8, 16'd5));
        loop_top = prog_len;
        emit(enc_i(OP_ADDIU, V0, V0, 16'd1));
        emit(enc_i(OP_ADDIU, 5'd8, 5'd8, 16'hFFFF));
        emit_branch(OP_BNE, 5'd8, ZERO, loop_top);
        emit_branch(OP_BEQ, ZERO, ZERO, prog_len + 2);
        emit(enc_i(OP_ADDIU, V0, V0, 16'd100));
        emit_branch(OP_BNE, ZERO, ZERO, prog_len + 2);
        emit(enc_i(OP_ADDIU, V0, V0, 16'd16));
        emit_branch(OP_BEQ, V0, ZERO, prog_len + 2);
        emit(enc_i(OP_ADDIU, V0, V0, 16'd32));
        emit_halt();
    endtask

    task automatic build_call();
        clear_program();
        emit(enc_i(OP_ADDIU, ZERO, V0, 16'd3));
        emit(enc_j(OP_JAL, SUB_INDEX));
        emit(enc_i(OP_ADDIU, V0, V0, 16'd10));
        emit(enc_j(OP_JAL, SUB_INDEX));
        emit(enc_j(OP_J, prog_len + 2));
        emit(enc_i(OP_ADDIU, V0, V0, 16'd1000));
        emit_halt();
        // Subroutine doubles v0
        prog_len = SUB_INDEX;
        emit(enc_r(FN_ADDU, V0, V0, V0));
        emit(enc_r(FN_JR, RA, ZERO, ZERO));
    endtask

    task automatic run_program(input string name, input bit stalled);
        int tests_before;
        int stall_budget;
        int stalls;
        expected_v0 = ref_run();
        stall_budget = stalled ? ref_steps : 0;
        test_name = name;
        deadline_cycle = cycle_count + 2 * ref_steps + stall_budget + 4;
        @(posedge clk);
        #1;
        reset = 1'b1;
        clk_enable = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        clk_enable = 1'b1;
        tests_before = tests_run;
        stalls = 0;
        -> run_started;
        while (tests_run == tests_before) begin
            @(posedge clk);
            #1;
            if (stalled && stalls < stall_budget && ($urandom % 3 == 0)) begin
                clk_enable = 1'b0;
                stalls++;
            end else begin
                clk_enable = 1'b1;
            end
        end
    endtask

    initial begin : compare_results
        int idx;
        int errors_before;
        int checks_before;
        forever begin
            @(run_started);
            @(negedge clk);
            while (active) begin
                @(negedge clk);
            end
            errors_before = error_count;
            checks_before = check_count;
            check_value("v0", expected_v0, register_v0);
            foreach (check_addrs[k]) begin
                idx = check_addrs[k];
                check_value($sformatf("mem[%0h]", idx * 4), ref_dmem[idx], dmem[idx]);
            end
            $display("test %s: %s, %0d checks", test_name,
                     (error_count == errors_before) ? "passed" : "FAILED",
                     check_count - checks_before);
            tests_run++;
        end
    end

    initial begin
        cycle_count = 0;
        do begin
            @(posedge clk);
            cycle_count++;
        end while (cycle_count <= deadline_cycle);
        $display("timeout: core never halted in test %s", test_name);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hcd1b));
        reset = 1'b1;
        clk_enable = 1'b0;
        tests_run = 0;
        check_count = 0;
        error_count = 0;
        deadline_cycle = 64;
        for (int i = 0; i < 4; i++) begin
            arith_ops[i] = $urandom;
        end
        build_arith();
        run_program("arith", 1'b0);
        build_imm();
        run_program("immediate", 1'b0);
        build_mem();
        run_program("load_store", 1'b0);
        build_branch();
        run_program("branch", 1'b0);
        build_call();
        run_program("call_return", 1'b0);
        build_arith();
        run_program("arith_stalled", 1'b1);
        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+design
design/mips_isa_pkg.sv
design/mips_ctrl_pkg.sv
design/mips_control.sv
design/mips_alu_control.sv
design/mips_alu.sv
design/mips_regfile.sv
design/mips_pc.sv
design/mips_cpu_harvard.sv
test/mips_cpu_properties.sv
test/mips_cpu_tb.sv
